// ==== sim.f ====
+incdir+logic
logic/dcache_pkg.sv
logic/dcache_port_arbiter.sv
logic/dcache_frontend.sv
logic/data_ram.sv
logic/dcache_subsystem_top.sv
tests/dcache_tb.sv

// ==== tests/dcache_tb.sv ====
// Directed tests of the three-port data cache; every address read is written first, RAM is not reset
`timescale 1ns/10ps

`include "dcache_settings.svh"

module dcache_tb;
    import dcache_pkg::*;

    localparam logic [1:0] PORT_CPU = 2'd0;
    localparam logic [1:0] PORT_DMA = 2'd1;
    localparam logic [1:0] PORT_FPU = 2'd2;
    localparam int LAT = `DC_RAM_LATENCY;
    // About 50 accesses of at most LAT+6 cycles each plus a wide margin
    localparam int MAX_CYCLES = 4000;

    logic     clk;
    logic     reset;
    mem_req_t cpu_req, dma_req, fpu_req;
    logic     cpu_access, dma_access, fpu_access;
    logic     cpu_ack, dma_ack, fpu_ack;
    data_t    cpu_rdata, dma_rdata, fpu_rdata;

    // Shadow of the RAM with the same aliasing on the low address bits
    data_t       ref_mem [1 << `DC_RAM_ADDR_BITS];
    logic [1:0]  ack_order [$];
    logic [31:0] lcg_state = 32'd70792;
    int          check_count = 0;
    int          error_count = 0;
    int          cycle_count = 0;
    string       current_test = "";

    dcache_subsystem_top DUT (.*);

    // ============================================================
    // Clock, watchdog, random data
    // ============================================================

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Ends the run if any ack never comes
    initial begin
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run stopped after %0d cycles, a port never saw its ack", MAX_CYCLES);
        $display("Test failures found");
        $finish;
    end

    function automatic data_t rand_word();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    // ============================================================
    // Reference model and compare tasks
    // ============================================================

    task automatic ref_write(input addr_t addr, input data_t wdata, input bytesel_t bytesel);
        logic [`DC_RAM_ADDR_BITS-1:0] idx;
        idx = addr[`DC_RAM_ADDR_BITS-1:0];
        if (bytesel[0])
            ref_mem[idx][7:0] = wdata[7:0];
        if (bytesel[1])
            ref_mem[idx][15:8] = wdata[15:8];
    endtask

    function automatic data_t ref_read(input addr_t addr);
        return ref_mem[addr[`DC_RAM_ADDR_BITS-1:0]];
    endfunction

    task automatic check_data(input string what, input data_t expected, input data_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error %s (%s): expected %h, actual %h",
                     current_test, what, expected, actual);
        end
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error %s (%s): expected %b, actual %b",
                     current_test, what, expected, actual);
        end
    endtask

    // Ack arrival order as port ids where 0 is cpu, 1 is dma and 2 is fpu
    task automatic check_order(input int pos, input logic [1:0] expected, input logic [1:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error %s (ack %0d): expected port %0d, actual port %0d",
                     current_test, pos, expected, actual);
        end
    endtask

    task automatic report_test(input int errs_before);
        $display("%s: %0d errors", current_test, error_count - errs_before);
    endtask

    // ============================================================
    // Port drivers
    // ============================================================

    task automatic drive_port(input logic [1:0] port, input mem_req_t req, input logic access);
        case (port)
            PORT_DMA: begin
                dma_req    = req;
                dma_access = access;
            end
            PORT_FPU: begin
                fpu_req    = req;
                fpu_access = access;
            end
            default: begin
                cpu_req    = req;
                cpu_access = access;
            end
        endcase
    endtask

    function automatic logic port_ack(input logic [1:0] port);
        return (port == PORT_DMA) ? dma_ack : (port == PORT_FPU) ? fpu_ack : cpu_ack;
    endfunction

    function automatic data_t port_rdata(input logic [1:0] port);
        return (port == PORT_DMA) ? dma_rdata : (port == PORT_FPU) ? fpu_rdata : cpu_rdata;
    endfunction

    // Holds access until ack and counts cycles from access rising to ack seen
    task automatic port_access(input logic [1:0] port, input mem_req_t req,
                               output data_t rdata, output int cycles);
        @(negedge clk);
        drive_port(port, req, 1'b1);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (port_ack(port) !== 1'b1);
        rdata = port_rdata(port);
        ack_order.push_back(port);
        drive_port(port, '0, 1'b0);
    endtask

    task automatic write_word(input logic [1:0] port, input addr_t addr, input data_t wdata,
                              input bytesel_t bytesel);
        data_t unused;
        int    cycles;
        ref_write(addr, wdata, bytesel);
        port_access(port, '{addr: addr, wdata: wdata, wr_en: 1'b1, bytesel: bytesel},
                    unused, cycles);
    endtask

    task automatic read_word(input logic [1:0] port, input addr_t addr,
                             output data_t rdata, output int cycles);
        port_access(port, '{addr: addr, wdata: '0, wr_en: 1'b0, bytesel: 2'b11}, rdata, cycles);
    endtask

    // ============================================================
    // Tests
    // ============================================================

    task automatic reset_values();
        int errs;
        errs = error_count;
        current_test = "reset_values";
        check_flag("cpu_ack", 1'b0, cpu_ack);
        check_flag("dma_ack", 1'b0, dma_ack);
        check_flag("fpu_ack", 1'b0, fpu_ack);
        check_data("cpu_rdata", '0, cpu_rdata);
        check_data("dma_rdata", '0, dma_rdata);
        check_data("fpu_rdata", '0, fpu_rdata);
        report_test(errs);
    endtask

    task automatic write_read_each_port();
        int    errs;
        int    cyc;
        data_t rd;
        addr_t addr;
        errs = error_count;
        current_test = "write_read_each_port";
        for (int p = 0; p < 3; p++) begin
            for (int i = 0; i < 4; i++)
                write_word(p[1:0], addr_t'('h100 + p * 16 + i), rand_word(), 2'b11);
            for (int i = 0; i < 4; i++) begin
                addr = addr_t'('h100 + p * 16 + i);
                read_word(p[1:0], addr, rd, cyc);
                check_data($sformatf("port %0d addr %h", p, addr), ref_read(addr), rd);
            end
        end
        report_test(errs);
    endtask

    task automatic byte_lane_merge();
        int    errs;
        int    cyc;
        data_t rd;
        errs = error_count;
        current_test = "byte_lane_merge";
        // Line never read so the merged word comes from the RAM
        write_word(PORT_CPU, 'h200, rand_word(), 2'b11);
        write_word(PORT_CPU, 'h200, rand_word(), 2'b01);
        write_word(PORT_CPU, 'h200, rand_word(), 2'b10);
        read_word(PORT_CPU, 'h200, rd, cyc);
        check_data("uncached line", ref_read('h200), rd);
        // Line cached first so the merges land in the line on write hits
        write_word(PORT_CPU, 'h210, rand_word(), 2'b11);
        read_word(PORT_CPU, 'h210, rd, cyc);
        write_word(PORT_CPU, 'h210, rand_word(), 2'b01);
        write_word(PORT_CPU, 'h210, rand_word(), 2'b10);
        read_word(PORT_CPU, 'h210, rd, cyc);
        check_data("cached line", ref_read('h210), rd);
        report_test(errs);
    endtask

    task automatic priority_order();
        int    errs;
        int    c_cyc, d_cyc, f_cyc;
        data_t c_rd, d_rd, f_rd;
        data_t wval;
        errs = error_count;
        current_test = "priority_order";
        wval = rand_word();
        ref_write('h300, wval, 2'b11);
        ack_order.delete();
        // All three start on the same falling edge
        fork
            port_access(PORT_CPU, '{addr: 'h120, wdata: '0, wr_en: 1'b0, bytesel: 2'b11},
                        c_rd, c_cyc);
            port_access(PORT_DMA, '{addr: 'h300, wdata: wval, wr_en: 1'b1, bytesel: 2'b11},
                        d_rd, d_cyc);
            port_access(PORT_FPU, '{addr: 'h110, wdata: '0, wr_en: 1'b0, bytesel: 2'b11},
                        f_rd, f_cyc);
        join
        check_order(0, PORT_DMA, ack_order[0]);
        check_order(1, PORT_FPU, ack_order[1]);
        check_order(2, PORT_CPU, ack_order[2]);
        check_data("fpu read", ref_read('h110), f_rd);
        check_data("cpu read", ref_read('h120), c_rd);
        read_word(PORT_CPU, 'h300, c_rd, c_cyc);
        check_data("dma write", ref_read('h300), c_rd);
        report_test(errs);
    endtask

    task automatic cross_port_coherency();
        int    errs;
        int    cyc;
        data_t rd;
        errs = error_count;
        current_test = "cross_port_coherency";
        write_word(PORT_CPU, 'h400, rand_word(), 2'b11);
        read_word(PORT_CPU, 'h400, rd, cyc);
        write_word(PORT_DMA, 'h400, rand_word(), 2'b11);
        read_word(PORT_FPU, 'h400, rd, cyc);
        check_data("fpu after dma write", ref_read('h400), rd);
        read_word(PORT_CPU, 'h400, rd, cyc);
        check_data("cpu after dma write", ref_read('h400), rd);
        report_test(errs);
    endtask

    task automatic hit_faster_than_miss();
        int    errs;
        int    miss_cyc, hit_cyc;
        data_t rd;
        addr_t alias_addr;
        errs = error_count;
        current_test = "hit_faster_than_miss";
        alias_addr = addr_t'('h500 + (1 << `DC_RAM_ADDR_BITS));
        write_word(PORT_FPU, 'h500, rand_word(), 2'b11);
        read_word(PORT_FPU, 'h500, rd, miss_cyc);
        check_data("first read", ref_read('h500), rd);
        read_word(PORT_FPU, 'h500, rd, hit_cyc);
        check_data("repeat read", ref_read('h500), rd);
        check_count++;
        if (miss_cyc - hit_cyc < LAT) begin
            error_count++;
            $display("%s: repeat read took %0d cycles against %0d for the first, too slow",
                     current_test, hit_cyc, miss_cyc);
        end
        // Same line and same RAM word but a different tag
        read_word(PORT_CPU, alias_addr, rd, miss_cyc);
        check_data("alias read", ref_read(alias_addr), rd);
        read_word(PORT_DMA, 'h500, rd, miss_cyc);
        check_data("read after alias", ref_read('h500), rd);
        report_test(errs);
    endtask

    // ============================================================
    // Main sequence
    // ============================================================

    initial begin
        reset      = 1'b1;
        cpu_req    = '0;
        dma_req    = '0;
        fpu_req    = '0;
        cpu_access = 1'b0;
        dma_access = 1'b0;
        fpu_access = 1'b0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        reset_values();
        write_read_each_port();
        byte_lane_merge();
        priority_order();
        cross_port_coherency();
        hit_faster_than_miss();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// ==== logic/dcache_subsystem_top.sv ====
// Three requesters sharing one data cache and RAM; one request in flight, losers wait with access held
`timescale 1ns/10ps

module dcache_subsystem_top (
    input  logic                 clk,
    input  logic                 reset,

    // CPU data port, lowest priority
    input  dcache_pkg::mem_req_t cpu_req,
    input  logic                 cpu_access,
    output logic                 cpu_ack,
    output dcache_pkg::data_t    cpu_rdata,

    // DMA port, highest priority
    input  dcache_pkg::mem_req_t dma_req,
    input  logic                 dma_access,
    output logic                 dma_ack,
    output dcache_pkg::data_t    dma_rdata,

    // FPU port
    input  dcache_pkg::mem_req_t fpu_req,
    input  logic                 fpu_access,
    output logic                 fpu_ack,
    output dcache_pkg::data_t    fpu_rdata
);
    import dcache_pkg::*;

    // ============================================================
    // Internal links
    // ============================================================

    // Arbiter to cache
    mem_req_t cache_req;
    logic     cache_access;
    logic     cache_ack;
    data_t    cache_rdata;

    // Cache to RAM
    mem_req_t ram_req;
    logic     ram_access;
    logic     ram_ack;
    data_t    ram_rdata;

    dcache_port_arbiter u_arbiter (
        .clk          (clk),
        .reset        (reset),
        .cpu_req      (cpu_req),
        .dma_req      (dma_req),
        .fpu_req      (fpu_req),
        .cpu_access   (cpu_access),
        .dma_access   (dma_access),
        .fpu_access   (fpu_access),
        .cpu_ack      (cpu_ack),
        .dma_ack      (dma_ack),
        .fpu_ack      (fpu_ack),
        .cpu_rdata    (cpu_rdata),
        .dma_rdata    (dma_rdata),
        .fpu_rdata    (fpu_rdata),
        .cache_req    (cache_req),
        .cache_access (cache_access),
        .cache_ack    (cache_ack),
        .cache_rdata  (cache_rdata)
    );

    dcache_frontend u_frontend (
        .clk          (clk),
        .reset        (reset),
        .cache_req    (cache_req),
        .cache_access (cache_access),
        .cache_ack    (cache_ack),
        .cache_rdata  (cache_rdata),
        .ram_req      (ram_req),
        .ram_access   (ram_access),
        .ram_ack      (ram_ack),
        .ram_rdata    (ram_rdata)
    );

    data_ram u_ram (
        .clk        (clk),
        .reset      (reset),
        .ram_req    (ram_req),
        .ram_access (ram_access),
        .ram_ack    (ram_ack),
        .ram_rdata  (ram_rdata)
    );

endmodule

// ==== logic/data_ram.sv ====
// Word RAM model with a fixed latency; decodes only the low DC_RAM_ADDR_BITS, contents are not reset
`timescale 1ns/10ps

`include "dcache_settings.svh"

module data_ram (
    input  logic                 clk,
    input  logic                 reset,
    input  dcache_pkg::mem_req_t ram_req,
    input  logic                 ram_access,
    output logic                 ram_ack,
    output dcache_pkg::data_t    ram_rdata
);
    import dcache_pkg::*;

    localparam int AW    = `DC_RAM_ADDR_BITS;
    localparam int LAT   = `DC_RAM_LATENCY;
    localparam int CNT_W = $clog2(LAT + 1);

    data_t mem [1 << AW];

    logic [AW-1:0]    word_addr;
    logic [CNT_W-1:0] cnt;
    logic             busy;
    logic             fire;

    // Higher address bits alias onto the same words
    assign word_addr = ram_req.addr[AW-1:0];

    // Access completes on this edge; nothing starts in the ack cycle
    assign fire = !ram_ack &&
                  (busy ? (cnt == CNT_W'(1)) : (ram_access && (LAT == 1)));

    // ============================================================
    // Latency counter
    // ============================================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ram_ack <= 1'b0;
            busy    <= 1'b0;
            cnt     <= '0;
        end else begin
            ram_ack <= fire;
            if (ram_ack) begin
                // Cool-down cycle after an ack
                busy <= 1'b0;
            end else if (busy) begin
                cnt <= cnt - CNT_W'(1);
                if (fire)
                    busy <= 1'b0;
            end else if (ram_access && (LAT > 1)) begin
                busy <= 1'b1;
                cnt  <= CNT_W'(LAT - 1);
            end
        end
    end

    // Write and read both happen at ack time
    always_ff @(posedge clk) begin
        if (fire) begin
            if (ram_req.wr_en)
                mem[word_addr] <= merge_bytes(mem[word_addr], ram_req.wdata, ram_req.bytesel);
            ram_rdata <= mem[word_addr];
        end
    end

endmodule

// ==== logic/dcache_frontend.sv ====
// Direct-mapped, one word per line, write-through with no allocate on write miss; one request at a time
`timescale 1ns/10ps

`include "dcache_settings.svh"

module dcache_frontend (
    input  logic                 clk,
    input  logic                 reset,

    // From the arbiter
    input  dcache_pkg::mem_req_t cache_req,
    input  logic                 cache_access,
    output logic                 cache_ack,
    output dcache_pkg::data_t    cache_rdata,

    // Toward the RAM
    output dcache_pkg::mem_req_t ram_req,
    output logic                 ram_access,
    input  logic                 ram_ack,
    input  dcache_pkg::data_t    ram_rdata
);
    import dcache_pkg::*;

    localparam int IDX_W = `DC_INDEX_BITS;
    localparam int TAG_W = $bits(addr_t) - IDX_W;
    localparam int LINES = 1 << IDX_W;

    // ============================================================
    // Line arrays
    // ============================================================

    logic [TAG_W-1:0] tag_arr [LINES];
    data_t            data_arr [LINES];
    logic [LINES-1:0] valid;

    // Address split of the incoming request
    logic [IDX_W-1:0] req_index;
    logic [TAG_W-1:0] req_tag;
    assign req_index = cache_req.addr[IDX_W-1:0];
    assign req_tag   = cache_req.addr[$bits(addr_t)-1:IDX_W];

    // Same split of the request sent to the RAM, used for the line update
    logic [IDX_W-1:0] fill_index;
    logic [TAG_W-1:0] fill_tag;
    assign fill_index = ram_req.addr[IDX_W-1:0];
    assign fill_tag   = ram_req.addr[$bits(addr_t)-1:IDX_W];

    // Registered line read, taken every cycle
    logic [TAG_W-1:0] tag_rd;
    data_t            data_rd;
    logic             valid_rd;

    logic hit;
    logic hit_q;
    assign hit = valid_rd && (tag_rd == req_tag);

    // ============================================================
    // Control state machine
    // ============================================================

    typedef enum logic [1:0] {
        FE_IDLE,
        FE_LOOKUP,
        FE_RAM_WAIT,
        FE_DONE
    } fe_state_t;

    fe_state_t state;

    // Line updates when the RAM answers
    logic fill_line;
    logic merge_line;
    assign fill_line  = (state == FE_RAM_WAIT) && ram_ack && !ram_req.wr_en;
    assign merge_line = (state == FE_RAM_WAIT) && ram_ack && ram_req.wr_en && hit_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= FE_IDLE;
            cache_ack   <= 1'b0;
            cache_rdata <= '0;
            ram_access  <= 1'b0;
            hit_q       <= 1'b0;
            valid       <= '0;
        end else begin
            case (state)
                FE_IDLE: begin
                    // Array read is launched this cycle
                    if (cache_access)
                        state <= FE_LOOKUP;
                end
                FE_LOOKUP: begin
                    if (!cache_req.wr_en && hit) begin
                        // Read hit answers straight from the line
                        cache_ack   <= 1'b1;
                        cache_rdata <= data_rd;
                        state       <= FE_DONE;
                    end else begin
                        // Miss or any write goes to the RAM
                        ram_access <= 1'b1;
                        hit_q      <= hit;
                        state      <= FE_RAM_WAIT;
                    end
                end
                FE_RAM_WAIT: begin
                    if (ram_ack) begin
                        ram_access  <= 1'b0;
                        cache_ack   <= 1'b1;
                        // Write data here is don't-care for the requester
                        cache_rdata <= ram_rdata;
                        state       <= FE_DONE;
                        if (fill_line)
                            valid[fill_index] <= 1'b1;
                    end
                end
                FE_DONE: begin
                    // Access ignored for this one cycle
                    cache_ack <= 1'b0;
                    state     <= FE_IDLE;
                end
                default: state <= FE_IDLE;
            endcase
        end
    end

    // ============================================================
    // Array read, request capture and line writes
    // ============================================================

    always_ff @(posedge clk) begin
        tag_rd   <= tag_arr[req_index];
        data_rd  <= data_arr[req_index];
        valid_rd <= valid[req_index];

        // Request copy toward the RAM, stable for the whole RAM access
        if (state == FE_LOOKUP)
            ram_req <= cache_req;

        if (fill_line) begin
            tag_arr[fill_index]  <= fill_tag;
            data_arr[fill_index] <= ram_rdata;
        end

        // Write hit keeps the cached copy in step with the RAM
        if (merge_line)
            data_arr[fill_index] <= merge_bytes(data_rd, ram_req.wdata, ram_req.bytesel);
    end

endmodule

// ==== logic/dcache_port_arbiter.sv ====
// Fixed priority DMA > FPU > CPU, non-preemptive; requesters hold access and request until ack
`timescale 1ns/10ps

module dcache_port_arbiter (
    input  logic                clk,
    input  logic                reset,

    // Requester side
    input  dcache_pkg::mem_req_t cpu_req,
    input  dcache_pkg::mem_req_t dma_req,
    input  dcache_pkg::mem_req_t fpu_req,
    input  logic                cpu_access,
    input  logic                dma_access,
    input  logic                fpu_access,
    output logic                cpu_ack,
    output logic                dma_ack,
    output logic                fpu_ack,
    output dcache_pkg::data_t   cpu_rdata,
    output dcache_pkg::data_t   dma_rdata,
    output dcache_pkg::data_t   fpu_rdata,

    // Cache side
    output dcache_pkg::mem_req_t cache_req,
    output logic                cache_access,
    input  logic                cache_ack,
    input  dcache_pkg::data_t   cache_rdata
);
    import dcache_pkg::*;

    // ============================================================
    // Grant state machine
    // ============================================================

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_SERVE_DMA,
        ARB_SERVE_FPU,
        ARB_SERVE_CPU
    } arb_state_t;

    arb_state_t state;
    arb_state_t next_state;

    // Serving flags, one cycle longer than the serve state
    logic serving_dma;
    logic serving_fpu;
    logic serving_cpu;

    // Access of whichever port the flags point at
    logic sel_access;

    always_comb begin
        next_state = state;
        case (state)
            ARB_IDLE: begin
                // No grant while a flag still lingers from the last one
                if (!serving_dma && !serving_fpu && !serving_cpu) begin
                    if (dma_access)
                        next_state = ARB_SERVE_DMA;
                    else if (fpu_access)
                        next_state = ARB_SERVE_FPU;
                    else if (cpu_access)
                        next_state = ARB_SERVE_CPU;
                end
            end
            ARB_SERVE_DMA,
            ARB_SERVE_FPU,
            ARB_SERVE_CPU: begin
                // Held until the cache finishes
                if (cache_ack)
                    next_state = ARB_IDLE;
            end
            default: next_state = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= ARB_IDLE;
            serving_dma <= 1'b0;
            serving_fpu <= 1'b0;
            serving_cpu <= 1'b0;
        end else begin
            state <= next_state;
            // Set on entry, cleared one cycle after leaving
            serving_dma <= (state == ARB_SERVE_DMA) || (next_state == ARB_SERVE_DMA);
            serving_fpu <= (state == ARB_SERVE_FPU) || (next_state == ARB_SERVE_FPU);
            serving_cpu <= (state == ARB_SERVE_CPU) || (next_state == ARB_SERVE_CPU);
        end
    end

    // ============================================================
    // Request routing toward the cache
    // ============================================================

    always_comb begin
        if (serving_dma) begin
            cache_req  = dma_req;
            sel_access = dma_access;
        end else if (serving_fpu) begin
            cache_req  = fpu_req;
            sel_access = fpu_access;
        end else if (serving_cpu) begin
            cache_req  = cpu_req;
            sel_access = cpu_access;
        end else begin
            cache_req  = '0;
            sel_access = 1'b0;
        end
    end

    // Dropped as soon as the serve state ends, the lingering flag only steers the mux
    assign cache_access = (state != ARB_IDLE) && sel_access;

    // ============================================================
    // Ack and read data back to the winner
    // ============================================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dma_ack   <= 1'b0;
            fpu_ack   <= 1'b0;
            cpu_ack   <= 1'b0;
            dma_rdata <= '0;
            fpu_rdata <= '0;
            cpu_rdata <= '0;
        end else begin
            // One-cycle pulse, one cycle after cache_ack
            dma_ack <= serving_dma && cache_ack;
            fpu_ack <= serving_fpu && cache_ack;
            cpu_ack <= serving_cpu && cache_ack;
            // rdata holds until that port's next ack
            if (serving_dma && cache_ack)
                dma_rdata <= cache_rdata;
            if (serving_fpu && cache_ack)
                fpu_rdata <= cache_rdata;
            if (serving_cpu && cache_ack)
                cpu_rdata <= cache_rdata;
        end
    end

endmodule

// ==== logic/dcache_pkg.sv ====
// Shared types for the data cache path; addresses are word addresses, byte lanes come from bytesel
package dcache_pkg;

    // ============================================================
    // Plain vector types
    // ============================================================

    // Word address, bits 19:1 of the byte address
    typedef logic [18:0] addr_t;

    // One data word
    typedef logic [15:0] data_t;

    // Byte enables, bit 0 is the low byte
    typedef logic [1:0] bytesel_t;

    // ============================================================
    // Request bundle
    // ============================================================

    // Same layout on requester ports, arbiter to cache and cache to RAM
    typedef struct packed {
        addr_t    addr;
        data_t    wdata;
        logic     wr_en;
        bytesel_t bytesel;
    } mem_req_t;

    // Merge the enabled bytes of new_word over old_word
    function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                          input bytesel_t bytesel);
        data_t merged;
        merged = old_word;
        if (bytesel[0])
            merged[7:0] = new_word[7:0];
        if (bytesel[1])
            merged[15:8] = new_word[15:8];
        return merged;
    endfunction

endpackage

// ==== logic/dcache_settings.svh ====
// Sizes for the data cache; DC_RAM_LATENCY must be at least 1 and the tag takes the address bits above the index
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// ============================================================
// Cache geometry
// ============================================================

// Index width, one 16-bit word per line
// 6 bits gives 64 lines, tag is the remaining 13 address bits
`define DC_INDEX_BITS 6

// ============================================================
// Backing RAM model
// ============================================================

// RAM depth in word address bits
// Only the low bits are decoded, so higher addresses alias
`define DC_RAM_ADDR_BITS 12

// Cycles from the RAM first seeing access to its ack
`define DC_RAM_LATENCY 3

`endif
